// File: files.f
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_unit_if.sv
hdl/int_alu.sv
hdl/ctrl_flow_unit.sv
hdl/mem_agu.sv
hdl/exec_result_reg.sv
hdl/exec_stage.sv
verif/exec_stage_tb.sv

// File: hdl/ctrl_flow_unit.sv
// control flow unit evaluating branch conditions and jal, jalr and branch targets
`include "exec_config.svh"

module ctrl_flow_unit
    import exec_pkg::*;
(
    input  insn_op_t              i_op,
    input  logic [`IMM12_W-1:0]   i_imm12,
    input  logic [`REG_IDX_W-1:0] i_rd,
    input  logic [`UIMM_W-1:0]    i_uimm,
    input  logic [`PC_W-1:0]      i_pc,
    input  logic [`XLEN-1:0]      i_rs1_value,
    input  logic [`XLEN-1:0]      i_rs2_value,
    exec_unit_if.unit             o_res
);

    branch_f3_e       f3;
    logic             taken;
    logic             f3_ok;
    logic [`PC_W-1:0] link;
    logic [`PC_W-1:0] jal_tgt;
    logic [`PC_W-1:0] br_tgt;
    logic [`PC_W-1:0] jalr_tgt;
    logic [`XLEN-1:0] jalr_sum;

    assign f3       = branch_f3_e'(i_op.funct3);
    assign link     = i_pc + 4;
    assign jal_tgt  = i_pc + {{(`PC_W-`UIMM_W-1){i_uimm[`UIMM_W-1]}}, i_uimm, 1'b0};
    // b-type offset is split across the imm12 and rd fields
    assign br_tgt   = i_pc + {{(`PC_W-13){i_imm12[11]}}, i_imm12[11], i_rd[0],
                              i_imm12[10:5], i_rd[4:1], 1'b0};
    assign jalr_sum = i_rs1_value + {{(`XLEN-`IMM12_W){i_imm12[`IMM12_W-1]}}, i_imm12};
    assign jalr_tgt = {jalr_sum[`PC_W-1:1], 1'b0};

    always_comb begin
        f3_ok = 1'b1;
        case (f3)
            BEQ:     taken = i_rs1_value == i_rs2_value;
            BNE:     taken = i_rs1_value != i_rs2_value;
            BLT:     taken = $signed(i_rs1_value) < $signed(i_rs2_value);
            BGE:     taken = $signed(i_rs1_value) >= $signed(i_rs2_value);
            BLTU:    taken = i_rs1_value < i_rs2_value;
            BGEU:    taken = i_rs1_value >= i_rs2_value;
            default: begin
                taken = 1'b0;
                f3_ok = 1'b0;  // funct3 2 and 3 are reserved
            end
        endcase
    end

    always_comb begin
        o_res.hit      = 1'b0;
        o_res.data     = '0;
        o_res.rd_write = 1'b0;
        o_res.jmp      = 1'b0;
        o_res.target   = '0;
        case (i_op.major)
            JAL, JALR: begin
                o_res.hit      = 1'b1;
                o_res.data     = {{(`XLEN-`PC_W){1'b0}}, link};
                o_res.rd_write = 1'b1;
                o_res.jmp      = 1'b1;
                o_res.target   = (i_op.major == JAL) ? jal_tgt : jalr_tgt;
            end
            BRANCH: begin
                o_res.hit    = f3_ok;
                o_res.jmp    = taken;
                o_res.target = taken ? br_tgt : '0;
            end
            default: ;
        endcase
    end

    assign o_res.mem_addr = '0;
    assign o_res.size     = SIZE_8;
    assign o_res.load     = 1'b0;
    assign o_res.store    = 1'b0;

    // fetch hands over aligned pcs, so every redirect stays halfword aligned
    a_tgt_align: assert final ($isunknown({o_res.jmp, o_res.target}) ||
                               !o_res.jmp || !o_res.target[0]);

endmodule

// File: hdl/exec_config.svh
// execute stage widths for data path, pc, immediate fields and register index
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// integer data path, rv64
`define XLEN      64

`define PC_W      32  // fetch side pc
`define IMM12_W   12  // i-type immediate, also funct7 + rs2 on r-type
`define UIMM_W    20  // u-type and j-type immediate field
`define REG_IDX_W 5

`endif

// File: hdl/exec_pkg.sv
// execute stage package with opcode, funct3 and access size encodings
package exec_pkg;

    // major opcodes, standard rv64i encodings
    typedef enum logic [6:0] {
        LOAD      = 7'b0000011,
        OP_IMM    = 7'b0010011,
        AUIPC     = 7'b0010111,
        OP_IMM_32 = 7'b0011011,
        STORE     = 7'b0100011,
        OP        = 7'b0110011,
        LUI       = 7'b0110111,
        OP_32     = 7'b0111011,
        BRANCH    = 7'b1100011,
        JALR      = 7'b1100111,
        JAL       = 7'b1101111
    } major_op_e;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

    // low two bits of load/store funct3, bit 2 marks unsigned loads
    typedef enum logic [1:0] {
        SIZE_8  = 2'b00,
        SIZE_16 = 2'b01,
        SIZE_32 = 2'b10,
        SIZE_64 = 2'b11
    } mem_size_e;

    typedef struct packed {
        logic [2:0] funct3;  // bits 9:7
        major_op_e  major;   // bits 6:0
    } insn_op_t;

endpackage

// File: hdl/exec_result_reg.sv
// execute output register merging unit results, with flush and unknown opcode squash
`include "exec_config.svh"

module exec_result_reg
    import exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`REG_IDX_W-1:0] i_rd,
    input  logic [`PC_W-1:0]      i_pc,
    input  logic                  i_flush,
    exec_unit_if.sink             i_alu,
    exec_unit_if.sink             i_ctrl,
    exec_unit_if.sink             i_mem,
    output logic [`XLEN-1:0]      o_data,
    output logic [`REG_IDX_W-1:0] o_rd,
    output logic                  o_wr_en,
    output logic [`XLEN-1:0]      o_mem_addr,
    output mem_size_e             o_mem_size,
    output logic                  o_load,
    output logic                  o_store,
    output logic                  o_is_jmp,
    output logic [`PC_W-1:0]      o_jmp_target,
    output logic [`PC_W-1:0]      o_pc
);

    logic             kill;
    logic             wr_ok;
    logic             jmp_ok;
    logic [`XLEN-1:0] sel_data;
    logic [`XLEN-1:0] sel_addr;
    logic [`PC_W-1:0] sel_target;
    mem_size_e        sel_size;

    // squash on flush or when no unit claims the opcode
    assign kill = i_flush | ~(i_alu.hit | i_ctrl.hit | i_mem.hit);

    // units zero what they do not own, so gating by hit and or-ing picks the owner
    assign sel_data   = ({`XLEN{i_alu.hit}} & i_alu.data) | ({`XLEN{i_ctrl.hit}} & i_ctrl.data)
                      | ({`XLEN{i_mem.hit}} & i_mem.data);
    assign sel_addr   = ({`XLEN{i_alu.hit}} & i_alu.mem_addr)
                      | ({`XLEN{i_ctrl.hit}} & i_ctrl.mem_addr)
                      | ({`XLEN{i_mem.hit}} & i_mem.mem_addr);
    assign sel_target = ({`PC_W{i_alu.hit}} & i_alu.target) | ({`PC_W{i_ctrl.hit}} & i_ctrl.target)
                      | ({`PC_W{i_mem.hit}} & i_mem.target);
    assign sel_size   = mem_size_e'(({2{i_alu.hit}} & i_alu.size) | ({2{i_ctrl.hit}} & i_ctrl.size)
                      | ({2{i_mem.hit}} & i_mem.size));

    assign wr_ok  = ~kill & ((i_alu.hit & i_alu.rd_write) | (i_ctrl.hit & i_ctrl.rd_write)
                  | (i_mem.hit & i_mem.rd_write));
    assign jmp_ok = ~kill & ((i_alu.hit & i_alu.jmp) | (i_ctrl.hit & i_ctrl.jmp)
                  | (i_mem.hit & i_mem.jmp));

    always_ff @(posedge clk) begin
        if (reset) begin
            o_pc         <= '0;
            o_data       <= '0;
            o_rd         <= '0;
            o_wr_en      <= 1'b0;
            o_mem_addr   <= '0;
            o_mem_size   <= SIZE_8;
            o_load       <= 1'b0;
            o_store      <= 1'b0;
            o_is_jmp     <= 1'b0;
            o_jmp_target <= '0;
        end else begin
            o_pc         <= i_pc;  // follows even through a flush
            o_data       <= kill ? '0 : sel_data;
            o_rd         <= wr_ok ? i_rd : '0;
            o_wr_en      <= wr_ok;
            o_mem_addr   <= kill ? '0 : sel_addr;
            o_mem_size   <= kill ? SIZE_8 : sel_size;
            o_load       <= ~kill & ((i_alu.hit & i_alu.load) | (i_ctrl.hit & i_ctrl.load)
                          | (i_mem.hit & i_mem.load));
            o_store      <= ~kill & ((i_alu.hit & i_alu.store) | (i_ctrl.hit & i_ctrl.store)
                          | (i_mem.hit & i_mem.store));
            o_is_jmp     <= jmp_ok;
            o_jmp_target <= jmp_ok ? sel_target : '0;
        end
    end

    // unit decoders must not overlap
    a_one_hit: assert property (@(posedge clk) disable iff (reset)
        $onehot0({i_alu.hit, i_ctrl.hit, i_mem.hit}));

    a_ld_st: assert property (@(posedge clk) disable iff (reset) !(o_load && o_store));

endmodule

// File: hdl/exec_stage.sv
// rv64 execute stage top connecting alu, control flow and address units to the output register
`include "exec_config.svh"

module exec_stage
    import exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  insn_op_t              i_op,
    input  logic [`IMM12_W-1:0]   i_imm12,
    input  logic [`REG_IDX_W-1:0] i_rd,
    input  logic [`UIMM_W-1:0]    i_uimm,
    input  logic [`PC_W-1:0]      i_pc,
    input  logic [`XLEN-1:0]      i_rs1_value,
    input  logic [`XLEN-1:0]      i_rs2_value,
    input  logic                  i_flush,
    output logic [`XLEN-1:0]      o_data,
    output logic [`REG_IDX_W-1:0] o_rd,
    output logic                  o_wr_en,
    output logic [`XLEN-1:0]      o_mem_addr,
    output mem_size_e             o_mem_size,
    output logic                  o_load,
    output logic                  o_store,
    output logic                  o_is_jmp,
    output logic [`PC_W-1:0]      o_jmp_target,
    output logic [`PC_W-1:0]      o_pc
);

    exec_unit_if alu_res ();
    exec_unit_if ctrl_res ();
    exec_unit_if mem_res ();

    int_alu int_alu_i (
        .i_op        (i_op),
        .i_imm12     (i_imm12),
        .i_uimm      (i_uimm),
        .i_pc        (i_pc),
        .i_rs1_value (i_rs1_value),
        .i_rs2_value (i_rs2_value),
        .o_res       (alu_res.unit)
    );

    ctrl_flow_unit ctrl_flow_unit_i (
        .i_op        (i_op),
        .i_imm12     (i_imm12),
        .i_rd        (i_rd),
        .i_uimm      (i_uimm),
        .i_pc        (i_pc),
        .i_rs1_value (i_rs1_value),
        .i_rs2_value (i_rs2_value),
        .o_res       (ctrl_res.unit)
    );

    mem_agu mem_agu_i (
        .i_op        (i_op),
        .i_imm12     (i_imm12),
        .i_rd        (i_rd),
        .i_rs1_value (i_rs1_value),
        .i_rs2_value (i_rs2_value),
        .o_res       (mem_res.unit)
    );

    // single pipeline register, one cycle latency
    exec_result_reg exec_result_reg_i (
        .clk          (clk),
        .reset        (reset),
        .i_rd         (i_rd),
        .i_pc         (i_pc),
        .i_flush      (i_flush),
        .i_alu        (alu_res.sink),
        .i_ctrl       (ctrl_res.sink),
        .i_mem        (mem_res.sink),
        .o_data       (o_data),
        .o_rd         (o_rd),
        .o_wr_en      (o_wr_en),
        .o_mem_addr   (o_mem_addr),
        .o_mem_size   (o_mem_size),
        .o_load       (o_load),
        .o_store      (o_store),
        .o_is_jmp     (o_is_jmp),
        .o_jmp_target (o_jmp_target),
        .o_pc         (o_pc)
    );

endmodule

// File: hdl/exec_unit_if.sv
// functional unit result bundle carrying one candidate result to the output register
`include "exec_config.svh"

interface exec_unit_if
    import exec_pkg::*;
();

    logic             hit;       // opcode recognised by this unit
    logic [`XLEN-1:0] data;
    logic             rd_write;
    logic [`XLEN-1:0] mem_addr;
    mem_size_e        size;
    logic             load;
    logic             store;
    logic             jmp;       // redirect fetch
    logic [`PC_W-1:0] target;

    modport unit (output hit, data, rd_write, mem_addr, size, load, store, jmp, target);

    modport sink (input hit, data, rd_write, mem_addr, size, load, store, jmp, target);

endinterface

// File: hdl/int_alu.sv
// integer alu with arithmetic, logic, compare and shift ops, W forms, lui and auipc
`include "exec_config.svh"

module int_alu
    import exec_pkg::*;
(
    input  insn_op_t              i_op,
    input  logic [`IMM12_W-1:0]   i_imm12,
    input  logic [`UIMM_W-1:0]    i_uimm,
    input  logic [`PC_W-1:0]      i_pc,
    input  logic [`XLEN-1:0]      i_rs1_value,
    input  logic [`XLEN-1:0]      i_rs2_value,
    exec_unit_if.unit             o_res
);

    alu_f3_e          f3;
    logic             is_imm;
    logic             is_w;
    logic             alt;
    logic             hit;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] imm_sext;
    logic [`XLEN-1:0] opb;
    logic [`XLEN-1:0] upper;
    logic [`XLEN-1:0] res64;
    logic [31:0]      a32;
    logic [31:0]      res32;
    logic [`XLEN-1:0] result;

    assign f3       = alu_f3_e'(i_op.funct3);
    assign is_imm   = (i_op.major == OP_IMM) || (i_op.major == OP_IMM_32);
    assign is_w     = (i_op.major == OP_32) || (i_op.major == OP_IMM_32);
    assign alt      = i_imm12[10];  // funct7 bit 5
    assign imm_sext = {{(`XLEN-`IMM12_W){i_imm12[`IMM12_W-1]}}, i_imm12};
    assign opb      = is_imm ? imm_sext : i_rs2_value;
    assign shamt    = is_w ? {1'b0, opb[4:0]} : opb[5:0];
    assign upper    = {{(`XLEN-32){i_uimm[`UIMM_W-1]}}, i_uimm, 12'h000};
    assign a32      = i_rs1_value[31:0];

    always_comb begin
        case (f3)
            ADD_SUB: res64 = (alt && !is_imm) ? i_rs1_value - opb : i_rs1_value + opb;
            SLL:     res64 = i_rs1_value << shamt;
            SLT:     res64 = {{(`XLEN-1){1'b0}}, $signed(i_rs1_value) < $signed(opb)};
            SLTU:    res64 = {{(`XLEN-1){1'b0}}, i_rs1_value < opb};
            XOR:     res64 = i_rs1_value ^ opb;
            SRL_SRA: begin
                if (alt)
                    res64 = $signed(i_rs1_value) >>> shamt;
                else
                    res64 = i_rs1_value >> shamt;
            end
            OR:      res64 = i_rs1_value | opb;
            default: res64 = i_rs1_value & opb;
        endcase
    end

    // word forms have only add/sub and shifts
    always_comb begin
        res32 = '0;
        case (f3)
            ADD_SUB: res32 = (alt && !is_imm) ? a32 - opb[31:0] : a32 + opb[31:0];
            SLL:     res32 = a32 << shamt[4:0];
            SRL_SRA: begin
                if (alt)
                    res32 = $signed(a32) >>> shamt[4:0];
                else
                    res32 = a32 >> shamt[4:0];
            end
            default: ;
        endcase
    end

    always_comb begin
        case (i_op.major)
            OP, OP_IMM, LUI, AUIPC: hit = 1'b1;
            OP_32, OP_IMM_32:       hit = (f3 == ADD_SUB) || (f3 == SLL) || (f3 == SRL_SRA);
            default:                hit = 1'b0;
        endcase
    end

    always_comb begin
        case (i_op.major)
            LUI:              result = upper;
            AUIPC:            result = upper + {{(`XLEN-`PC_W){1'b0}}, i_pc};
            OP_32, OP_IMM_32: result = {{(`XLEN-32){res32[31]}}, res32};
            default:          result = res64;
        endcase
    end

    assign o_res.hit      = hit;
    assign o_res.data     = hit ? result : '0;
    assign o_res.rd_write = hit;
    assign o_res.mem_addr = '0;
    assign o_res.size     = SIZE_8;
    assign o_res.load     = 1'b0;
    assign o_res.store    = 1'b0;
    assign o_res.jmp      = 1'b0;
    assign o_res.target   = '0;

endmodule

// File: hdl/mem_agu.sv
// memory address unit producing load/store effective address, store data and size
`include "exec_config.svh"

module mem_agu
    import exec_pkg::*;
(
    input  insn_op_t              i_op,
    input  logic [`IMM12_W-1:0]   i_imm12,
    input  logic [`REG_IDX_W-1:0] i_rd,
    input  logic [`XLEN-1:0]      i_rs1_value,
    input  logic [`XLEN-1:0]      i_rs2_value,
    exec_unit_if.unit             o_res
);

    mem_size_e        size;
    logic [11:0]      st_off;
    logic [`XLEN-1:0] ld_addr;
    logic [`XLEN-1:0] st_addr;
    logic [`XLEN-1:0] st_data;

    assign size    = mem_size_e'(i_op.funct3[1:0]);
    assign st_off  = {i_imm12[11:5], i_rd};  // s-type offset
    assign ld_addr = i_rs1_value + {{(`XLEN-`IMM12_W){i_imm12[`IMM12_W-1]}}, i_imm12};
    assign st_addr = i_rs1_value + {{(`XLEN-12){st_off[11]}}, st_off};

    always_comb begin
        case (size)
            SIZE_8:  st_data = {{(`XLEN-8){1'b0}}, i_rs2_value[7:0]};
            SIZE_16: st_data = {{(`XLEN-16){1'b0}}, i_rs2_value[15:0]};
            SIZE_32: st_data = {{(`XLEN-32){1'b0}}, i_rs2_value[31:0]};
            default: st_data = i_rs2_value;
        endcase
    end

    always_comb begin
        o_res.hit      = 1'b0;
        o_res.data     = '0;
        o_res.mem_addr = '0;
        o_res.size     = SIZE_8;
        o_res.load     = 1'b0;
        o_res.store    = 1'b0;
        case (i_op.major)
            LOAD: begin
                if (i_op.funct3 != 3'b111) begin  // no unsigned 64-bit load
                    o_res.hit      = 1'b1;
                    o_res.load     = 1'b1;
                    o_res.mem_addr = ld_addr;
                    o_res.size     = size;
                end
            end
            STORE: begin
                if (!i_op.funct3[2]) begin
                    o_res.hit      = 1'b1;
                    o_res.store    = 1'b1;
                    o_res.mem_addr = st_addr;
                    o_res.data     = st_data;
                    o_res.size     = size;
                end
            end
            default: ;
        endcase
    end

    assign o_res.rd_write = 1'b0;
    assign o_res.jmp      = 1'b0;
    assign o_res.target   = '0;

endmodule

// File: verif/exec_stage_tb.sv
// directed testbench for the rv64 execute stage with a rule based reference model
`include "exec_config.svh"

module exec_stage_tb
    import exec_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cycles = 2000;  // roughly 3x the ~590 cycles the tests apply

    logic                  clk = 1'b0;
    logic                  reset;
    insn_op_t              i_op;
    logic [`IMM12_W-1:0]   i_imm12;
    logic [`REG_IDX_W-1:0] i_rd;
    logic [`UIMM_W-1:0]    i_uimm;
    logic [`PC_W-1:0]      i_pc;
    logic [`XLEN-1:0]      i_rs1_value;
    logic [`XLEN-1:0]      i_rs2_value;
    logic                  i_flush;
    logic [`XLEN-1:0]      o_data;
    logic [`REG_IDX_W-1:0] o_rd;
    logic                  o_wr_en;
    logic [`XLEN-1:0]      o_mem_addr;
    mem_size_e             o_mem_size;
    logic                  o_load;
    logic                  o_store;
    logic                  o_is_jmp;
    logic [`PC_W-1:0]      o_jmp_target;
    logic [`PC_W-1:0]      o_pc;

    // expected outputs for the instruction in flight
    logic [`XLEN-1:0]      exp_data;
    logic [`REG_IDX_W-1:0] exp_rd;
    logic                  exp_wr;
    logic [`XLEN-1:0]      exp_addr;
    mem_size_e             exp_size;
    logic                  exp_load;
    logic                  exp_store;
    logic                  exp_jmp;
    logic [`PC_W-1:0]      exp_target;
    logic [`PC_W-1:0]      exp_pc;

    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycles = 0;

    major_op_e  alu_ops[6]  = '{OP, OP_IMM, OP_32, OP_IMM_32, LUI, AUIPC};
    branch_f3_e br_kinds[6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};

    exec_stage exec_stage_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run went past %0d cycles without finishing", max_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_data(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_rd(input string name, input logic [`REG_IDX_W-1:0] exp,
                            input logic [`REG_IDX_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_size(input string name, input mem_size_e exp, input mem_size_e act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_target(input string name, input logic [`PC_W-1:0] exp,
                                input logic [`PC_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    function automatic logic [`XLEN-1:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    task automatic clear_expected();
        exp_data   = '0;
        exp_rd     = '0;
        exp_wr     = 1'b0;
        exp_addr   = '0;
        exp_size   = SIZE_8;
        exp_load   = 1'b0;
        exp_store  = 1'b0;
        exp_jmp    = 1'b0;
        exp_target = '0;
    endtask

    // reference model of the execute rules
    task automatic predict(input insn_op_t op, input logic [`IMM12_W-1:0] imm12,
                           input logic [`REG_IDX_W-1:0] rd, input logic [`UIMM_W-1:0] uimm,
                           input logic [`PC_W-1:0] pc, input logic [`XLEN-1:0] rs1,
                           input logic [`XLEN-1:0] rs2, input logic flush);
        logic [`XLEN-1:0] imm_s;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] upper;
        logic [`XLEN-1:0] sum;
        logic [31:0]      w;
        logic [11:0]      soff;
        logic [12:0]      boff;
        logic             taken;
        logic             valid;
        clear_expected();
        exp_pc = pc;
        valid  = 1'b1;
        imm_s  = {{(`XLEN-12){imm12[11]}}, imm12};
        b      = (op.major == OP_IMM || op.major == OP_IMM_32) ? imm_s : rs2;
        upper  = {{(`XLEN-32){uimm[19]}}, uimm, 12'h000};
        case (op.major)
            OP, OP_IMM: begin
                exp_wr = 1'b1;
                case (op.funct3)
                    3'd0: exp_data = (op.major == OP && imm12[10]) ? rs1 - b : rs1 + b;
                    3'd1: exp_data = rs1 << b[5:0];
                    3'd2: exp_data = ($signed(rs1) < $signed(b)) ? 64'd1 : 64'd0;
                    3'd3: exp_data = (rs1 < b) ? 64'd1 : 64'd0;
                    3'd4: exp_data = rs1 ^ b;
                    3'd5: begin
                        if (imm12[10])
                            exp_data = $signed(rs1) >>> b[5:0];
                        else
                            exp_data = rs1 >> b[5:0];
                    end
                    3'd6: exp_data = rs1 | b;
                    default: exp_data = rs1 & b;
                endcase
            end
            OP_32, OP_IMM_32: begin
                exp_wr = 1'b1;
                w = '0;
                case (op.funct3)
                    3'd0: begin
                        if (op.major == OP_32 && imm12[10])
                            w = rs1[31:0] - b[31:0];
                        else
                            w = rs1[31:0] + b[31:0];
                    end
                    3'd1: w = rs1[31:0] << b[4:0];
                    3'd5: begin
                        if (imm12[10])
                            w = $signed(rs1[31:0]) >>> b[4:0];
                        else
                            w = rs1[31:0] >> b[4:0];
                    end
                    default: valid = 1'b0;
                endcase
                exp_data = {{(`XLEN-32){w[31]}}, w};
            end
            LUI: begin
                exp_wr   = 1'b1;
                exp_data = upper;
            end
            AUIPC: begin
                exp_wr   = 1'b1;
                exp_data = upper + {{(`XLEN-`PC_W){1'b0}}, pc};
            end
            JAL, JALR: begin
                sum        = rs1 + imm_s;
                exp_wr     = 1'b1;
                exp_jmp    = 1'b1;
                exp_data   = {{(`XLEN-`PC_W){1'b0}}, pc + 32'd4};
                if (op.major == JAL)
                    exp_target = pc + {{11{uimm[19]}}, uimm, 1'b0};
                else
                    exp_target = {sum[31:1], 1'b0};
            end
            BRANCH: begin
                boff = {imm12[11], rd[0], imm12[10:5], rd[4:1], 1'b0};
                case (op.funct3)
                    3'd0: taken = rs1 == rs2;
                    3'd1: taken = rs1 != rs2;
                    3'd4: taken = $signed(rs1) < $signed(rs2);
                    3'd5: taken = $signed(rs1) >= $signed(rs2);
                    3'd6: taken = rs1 < rs2;
                    3'd7: taken = rs1 >= rs2;
                    default: begin
                        taken = 1'b0;
                        valid = 1'b0;
                    end
                endcase
                if (taken) begin
                    exp_jmp    = 1'b1;
                    exp_target = pc + {{19{boff[12]}}, boff};
                end
            end
            LOAD: begin
                if (op.funct3 == 3'd7) begin
                    valid = 1'b0;
                end else begin
                    exp_load = 1'b1;
                    exp_addr = rs1 + imm_s;
                    exp_size = mem_size_e'(op.funct3[1:0]);
                end
            end
            STORE: begin
                soff = {imm12[11:5], rd};
                if (op.funct3[2]) begin
                    valid = 1'b0;
                end else begin
                    exp_store = 1'b1;
                    exp_addr  = rs1 + {{(`XLEN-12){soff[11]}}, soff};
                    exp_size  = mem_size_e'(op.funct3[1:0]);
                    case (op.funct3[1:0])
                        2'd0: exp_data = rs2 & 64'h0000_0000_0000_00ff;
                        2'd1: exp_data = rs2 & 64'h0000_0000_0000_ffff;
                        2'd2: exp_data = rs2 & 64'h0000_0000_ffff_ffff;
                        default: exp_data = rs2;
                    endcase
                end
            end
            default: valid = 1'b0;
        endcase
        if (flush || !valid)
            clear_expected();
        exp_rd = exp_wr ? rd : '0;
    endtask

    task automatic check_outputs();
        check_data("o_data", exp_data, o_data);
        check_rd("o_rd", exp_rd, o_rd);
        check_flag("o_wr_en", exp_wr, o_wr_en);
        check_data("o_mem_addr", exp_addr, o_mem_addr);
        check_size("o_mem_size", exp_size, o_mem_size);
        check_flag("o_load", exp_load, o_load);
        check_flag("o_store", exp_store, o_store);
        check_flag("o_is_jmp", exp_jmp, o_is_jmp);
        check_target("o_jmp_target", exp_target, o_jmp_target);
        check_target("o_pc", exp_pc, o_pc);
    endtask

    // drive at a falling edge, result is checked at the next falling edge
    task automatic issue(input insn_op_t op, input logic [`IMM12_W-1:0] imm12,
                         input logic [`REG_IDX_W-1:0] rd, input logic [`UIMM_W-1:0] uimm,
                         input logic [`PC_W-1:0] pc, input logic [`XLEN-1:0] rs1,
                         input logic [`XLEN-1:0] rs2, input logic flush);
        predict(op, imm12, rd, uimm, pc, rs1, rs2, flush);
        i_op        = op;
        i_imm12     = imm12;
        i_rd        = rd;
        i_uimm      = uimm;
        i_pc        = pc;
        i_rs1_value = rs1;
        i_rs2_value = rs2;
        i_flush     = flush;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d mismatches", name, errors - start);
        end
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        check_flag("o_wr_en", 1'b0, o_wr_en);
        check_flag("o_load", 1'b0, o_load);
        check_flag("o_store", 1'b0, o_store);
        check_flag("o_is_jmp", 1'b0, o_is_jmp);
        report_test("reset", start);
    endtask

    task automatic test_alu();
        int               start;
        insn_op_t         op;
        logic [11:0]      imm;
        logic [2:0]       f3;
        logic             alt;
        logic [`XLEN-1:0] rs1;
        start = errors;
        for (int n = 0; n < 200; n++) begin
            op.major = alu_ops[n % 6];
            f3       = 3'($urandom);
            alt      = 1'($urandom);
            imm      = 12'($urandom);
            rs1      = rand_word();
            if (op.major == OP_32 || op.major == OP_IMM_32)
                f3 = (f3[0]) ? 3'd1 : ((f3[1]) ? 3'd5 : 3'd0);
            if (op.major == OP || op.major == OP_32)
                imm = {1'b0, alt & (f3 == 3'd0 || f3 == 3'd5), 5'b0, imm[4:0]};
            else if (f3 == 3'd1 || f3 == 3'd5)
                imm = {1'b0, alt & (f3 == 3'd5), 4'b0, imm[5] & (op.major == OP_IMM), imm[4:0]};
            op.funct3 = f3;
            issue(op, imm, 5'($urandom), 20'($urandom), $urandom,
                  rs1, (n % 7 == 0) ? rs1 : rand_word(), 1'b0);
        end
        report_test("alu", start);
    endtask

    task automatic test_ctrl_flow();
        int               start;
        insn_op_t         op;
        logic [`XLEN-1:0] rs1;
        logic [`XLEN-1:0] rs2;
        start = errors;
        for (int k = 0; k < 6; k++) begin
            for (int j = 0; j < 40; j++) begin
                rs1 = rand_word();
                case (j % 4)
                    0: rs2 = rs1;
                    1: rs2 = rand_word();
                    2: rs2 = rs1 ^ 64'h8000_0000_0000_0000;  // sign differs
                    default: rs2 = rs1 + 64'($urandom_range(2, 0)) - 64'd1;
                endcase
                op.major  = BRANCH;
                op.funct3 = br_kinds[k];
                issue(op, 12'($urandom), 5'($urandom), 20'($urandom), {$urandom} & ~32'h3,
                      rs1, rs2, 1'b0);
            end
        end
        for (int j = 0; j < 40; j++) begin
            op.major  = (j < 20) ? JAL : JALR;
            op.funct3 = 3'b000;
            issue(op, 12'($urandom), 5'($urandom), 20'($urandom), {$urandom} & ~32'h3,
                  rand_word(), rand_word(), 1'b0);
        end
        report_test("control flow", start);
    endtask

    task automatic test_mem();
        int       start;
        insn_op_t op;
        start = errors;
        for (int f = 0; f < 7; f++) begin
            for (int j = 0; j < 8; j++) begin
                op.major  = LOAD;
                op.funct3 = 3'(f);
                issue(op, 12'($urandom), 5'($urandom), 20'($urandom), $urandom,
                      rand_word(), rand_word(), 1'b0);
            end
        end
        for (int f = 0; f < 4; f++) begin
            for (int j = 0; j < 10; j++) begin
                op.major  = STORE;
                op.funct3 = 3'(f);
                issue(op, 12'($urandom), 5'($urandom), 20'($urandom), $urandom,
                      rand_word(), rand_word(), 1'b0);
            end
        end
        report_test("load store", start);
    endtask

    task automatic test_flush();
        int       start;
        insn_op_t op;
        start = errors;
        op.major  = OP;
        op.funct3 = 3'd0;
        issue(op, 12'h000, 5'd7, 20'h0, 32'h0000_1000, rand_word(), rand_word(), 1'b1);
        op.major = JAL;
        issue(op, 12'h000, 5'd1, 20'h00040, 32'h0000_2000, rand_word(), rand_word(), 1'b1);
        op.major  = STORE;
        op.funct3 = 3'd3;
        issue(op, 12'h010, 5'd4, 20'h0, 32'h0000_3000, rand_word(), rand_word(), 1'b1);
        report_test("flush", start);
    endtask

    task automatic test_unknown();
        int       start;
        insn_op_t op;
        start = errors;
        op.funct3 = 3'd0;
        op.major  = major_op_e'(7'b1110011);  // system
        issue(op, 12'h001, 5'd3, 20'h12345, 32'h0000_4000, rand_word(), rand_word(), 1'b0);
        op.major = major_op_e'(7'b0001111);  // misc-mem
        issue(op, 12'h0ff, 5'd9, 20'h0, 32'h0000_4004, rand_word(), rand_word(), 1'b0);
        report_test("unknown opcode", start);
    endtask

    initial begin
        void'($urandom(81724));
        reset       = 1'b1;
        i_op        = '0;
        i_imm12     = '0;
        i_rd        = '0;
        i_uimm      = '0;
        i_pc        = '0;
        i_rs1_value = '0;
        i_rs2_value = '0;
        i_flush     = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        test_reset();
        test_alu();
        test_ctrl_flow();
        test_mem();
        test_flush();
        test_unknown();

        $display("tests passed %0d, failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
